/* logic/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// datapath and bus widths
`define XLEN      64
`define ADDR_W    32
`define ID_W      4

// bus ids of the two read requesters
`define LOAD_ID   2
`define FETCH_ID  1

// data ram depth in 64-bit words
`define RAM_WORDS 256

`endif

/* logic/mem_pkg.sv */
`include "mem_defs.svh"

package mem_pkg;

    // access size and extension of a load
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU
    } load_op_e;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        DONE
    } ld_state_e;

    typedef struct packed {
        load_op_e            op;
        logic [`ADDR_W-1:0]  base;
        logic [`ADDR_W-1:0]  offset;
        logic [4:0]          rd;      // destination register tag
    } ld_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]    data;
        logic [4:0]          rd;
        logic                fault;   // misaligned access
    } ld_rsp_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]  addr;    // doubleword aligned
        logic [`ID_W-1:0]    id;
    } rd_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]    data;
        logic [`ID_W-1:0]    id;
    } rd_rsp_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]  addr;
        logic [`XLEN-1:0]    data;
        logic [7:0]          strb;    // one enable per byte
    } wr_req_t;

endpackage

/* logic/load_unit.sv */
`include "mem_defs.svh"

module load_unit import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ld_req_valid,
    input  ld_req_t   ld_req,
    output logic      ld_req_ready,
    output logic      rd_req_valid,
    output rd_req_t   rd_req,
    input  logic      rd_req_ready,
    input  logic      rd_rsp_valid,
    input  rd_rsp_t   rd_rsp,
    output logic      rd_rsp_ready,
    output logic      ld_rsp_valid,
    output ld_rsp_t   ld_rsp,
    input  logic      ld_rsp_ready
);

    ld_state_e          state_q;
    load_op_e           op_q;
    logic [`ADDR_W-1:0] addr_q;
    logic [4:0]         rd_q;
    logic [`XLEN-1:0]   data_q;
    logic               fault_q;

    logic [`ADDR_W-1:0] ld_addr;
    logic               misaligned;
    logic               ld_fire;
    logic               rsp_take;
    logic [`XLEN-1:0]   lane;
    logic [`XLEN-1:0]   ld_data;

    assign ld_addr = ld_req.base + ld_req.offset;   // effective address
    assign ld_fire = ld_req_valid && ld_req_ready;

    always_comb begin
        case (ld_req.op)
            LH, LHU: misaligned = ld_addr[0];
            LW, LWU: misaligned = |ld_addr[1:0];
            LD:      misaligned = |ld_addr[2:0];
            default: misaligned = 1'b0;              // bytes never misalign
        endcase
    end

    assign ld_req_ready = (state_q == IDLE);
    assign rd_req_valid = (state_q == ISSUE);
    assign rd_rsp_ready = (state_q == WAIT);
    assign ld_rsp_valid = (state_q == DONE);

    assign rd_req.addr = {addr_q[`ADDR_W-1:3], 3'b000};
    assign rd_req.id   = `ID_W'(`LOAD_ID);

    // only our own id counts as the answer
    assign rsp_take = rd_rsp_valid && rd_rsp_ready && (rd_rsp.id == `ID_W'(`LOAD_ID));

    // move the addressed lane down to bit 0
    assign lane = rd_rsp.data >> {addr_q[2:0], 3'b000};

    always_comb begin
        case (op_q)
            LB:      ld_data = {{(`XLEN-8){lane[7]}}, lane[7:0]};
            LH:      ld_data = {{(`XLEN-16){lane[15]}}, lane[15:0]};
            LW:      ld_data = {{(`XLEN-32){lane[31]}}, lane[31:0]};
            LBU:     ld_data = {{(`XLEN-8){1'b0}}, lane[7:0]};
            LHU:     ld_data = {{(`XLEN-16){1'b0}}, lane[15:0]};
            LWU:     ld_data = {{(`XLEN-32){1'b0}}, lane[31:0]};
            LD:      ld_data = rd_rsp.data;          // whole doubleword
            default: ld_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ld_fire)
                        state_q <= misaligned ? DONE : ISSUE;
                end
                ISSUE: begin
                    if (rd_req_ready)
                        state_q <= WAIT;
                end
                WAIT: begin
                    if (rsp_take)
                        state_q <= DONE;
                end
                DONE: begin
                    if (ld_rsp_ready)
                        state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request and result payload
    always_ff @(posedge clk) begin
        if (ld_fire) begin
            op_q    <= ld_req.op;
            addr_q  <= ld_addr;
            rd_q    <= ld_req.rd;
            fault_q <= misaligned;
            data_q  <= '0;                          // stays zero on a fault
        end else if (rsp_take) begin
            data_q  <= ld_data;
        end
    end

    assign ld_rsp.data  = data_q;
    assign ld_rsp.rd    = rd_q;
    assign ld_rsp.fault = fault_q;

    a_rd_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req));

    a_ld_rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
        ld_rsp_valid && !ld_rsp_ready |=> state_q == DONE && $stable(ld_rsp));

endmodule

/* logic/read_arbiter.sv */
`include "mem_defs.svh"

module read_arbiter import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ld_rd_req_valid,
    input  rd_req_t  ld_rd_req,
    output logic     ld_rd_req_ready,
    input  logic     if_rd_req_valid,
    input  rd_req_t  if_rd_req,
    output logic     if_rd_req_ready,
    output logic     ld_rd_rsp_valid,
    output rd_rsp_t  ld_rd_rsp,
    input  logic     ld_rd_rsp_ready,
    output logic     if_rd_rsp_valid,
    output rd_rsp_t  if_rd_rsp,
    input  logic     if_rd_rsp_ready,
    output logic     ram_rd_req_valid,
    output rd_req_t  ram_rd_req,
    input  logic     ram_rd_req_ready,
    input  logic     ram_rd_rsp_valid,
    input  rd_rsp_t  ram_rd_rsp,
    output logic     ram_rd_rsp_ready
);

    logic last_if_q;    // fetch won the last transfer
    logic hold_q;       // request stalled last cycle
    logic hold_sel_q;
    logic sel_if;
    logic rsp_to_ld;
    logic rsp_to_if;

    always_comb begin
        if (hold_q)
            sel_if = hold_sel_q;                    // keep the stalled grant
        else if (ld_rd_req_valid && if_rd_req_valid)
            sel_if = !last_if_q;
        else
            sel_if = if_rd_req_valid;
    end

    assign ram_rd_req_valid = ld_rd_req_valid || if_rd_req_valid;
    assign ram_rd_req       = sel_if ? if_rd_req : ld_rd_req;
    assign ld_rd_req_ready  = ram_rd_req_ready && !sel_if;
    assign if_rd_req_ready  = ram_rd_req_ready && sel_if;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_if_q  <= 1'b0;
            hold_q     <= 1'b0;
            hold_sel_q <= 1'b0;
        end else begin
            if (ram_rd_req_valid && ram_rd_req_ready)
                last_if_q <= sel_if;
            hold_q     <= ram_rd_req_valid && !ram_rd_req_ready;
            hold_sel_q <= sel_if;
        end
    end

    // response routing by id
    assign rsp_to_ld = (ram_rd_rsp.id == `ID_W'(`LOAD_ID));
    assign rsp_to_if = (ram_rd_rsp.id == `ID_W'(`FETCH_ID));

    assign ld_rd_rsp_valid = ram_rd_rsp_valid && rsp_to_ld;
    assign if_rd_rsp_valid = ram_rd_rsp_valid && rsp_to_if;
    assign ld_rd_rsp       = ram_rd_rsp;
    assign if_rd_rsp       = ram_rd_rsp;

    always_comb begin
        if (rsp_to_ld)
            ram_rd_rsp_ready = ld_rd_rsp_ready;
        else if (rsp_to_if)
            ram_rd_rsp_ready = if_rd_rsp_ready;
        else
            ram_rd_rsp_ready = 1'b1;                // unknown id is drained
    end

    a_rsp_id_known: assert property (@(posedge clk) disable iff (!rst_n)
        ram_rd_rsp_valid |-> rsp_to_ld || rsp_to_if);

endmodule

/* logic/data_ram.sv */
`include "mem_defs.svh"

module data_ram import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rd_req_valid,
    input  rd_req_t  rd_req,
    output logic     rd_req_ready,
    output logic     rd_rsp_valid,
    output rd_rsp_t  rd_rsp,
    input  logic     rd_rsp_ready,
    input  logic     wr_valid,
    input  wr_req_t  wr
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [`XLEN-1:0] mem [`RAM_WORDS];

    logic             s1_valid;     // middle stage
    rd_rsp_t          s1;
    logic             s2_valid;     // output stage
    rd_rsp_t          s2;

    logic             s2_free;
    logic             rd_fire;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = rd_req.addr[IDX_W+2:3];
    assign wr_idx = wr.addr[IDX_W+2:3];

    assign s2_free      = !s2_valid || rd_rsp_ready;
    assign rd_req_ready = !s1_valid || s2_free;
    assign rd_fire      = rd_req_valid && rd_req_ready;

    // byte-enabled write port
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            for (int b = 0; b < 8; b++) begin
                if (wr.strb[b])
                    mem[wr_idx][8*b +: 8] <= wr.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s2_free)
                s2_valid <= s1_valid;
            if (rd_fire)
                s1_valid <= 1'b1;
            else if (s2_free)
                s1_valid <= 1'b0;                   // moved on to output
        end
    end

    always_ff @(posedge clk) begin
        if (s2_free && s1_valid)
            s2 <= s1;
        if (rd_fire) begin
            s1.data <= mem[rd_idx];
            s1.id   <= rd_req.id;
        end
    end

    assign rd_rsp_valid = s2_valid;
    assign rd_rsp       = s2;

endmodule

/* logic/load_subsys_top.sv */
module load_subsys_top import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ld_req_valid,
    input  ld_req_t  ld_req,
    output logic     ld_req_ready,
    output logic     ld_rsp_valid,
    output ld_rsp_t  ld_rsp,
    input  logic     ld_rsp_ready,
    input  logic     if_rd_req_valid,
    input  rd_req_t  if_rd_req,
    output logic     if_rd_req_ready,
    output logic     if_rd_rsp_valid,
    output rd_rsp_t  if_rd_rsp,
    input  logic     if_rd_rsp_ready,
    input  logic     wr_valid,
    input  wr_req_t  wr
);

    // load unit to arbiter
    logic     ld_rd_req_valid;
    rd_req_t  ld_rd_req;
    logic     ld_rd_req_ready;
    logic     ld_rd_rsp_valid;
    rd_rsp_t  ld_rd_rsp;
    logic     ld_rd_rsp_ready;

    // arbiter to ram
    logic     ram_rd_req_valid;
    rd_req_t  ram_rd_req;
    logic     ram_rd_req_ready;
    logic     ram_rd_rsp_valid;
    rd_rsp_t  ram_rd_rsp;
    logic     ram_rd_rsp_ready;

    load_unit u_load_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .ld_req_valid (ld_req_valid),
        .ld_req       (ld_req),
        .ld_req_ready (ld_req_ready),
        .rd_req_valid (ld_rd_req_valid),
        .rd_req       (ld_rd_req),
        .rd_req_ready (ld_rd_req_ready),
        .rd_rsp_valid (ld_rd_rsp_valid),
        .rd_rsp       (ld_rd_rsp),
        .rd_rsp_ready (ld_rd_rsp_ready),
        .ld_rsp_valid (ld_rsp_valid),
        .ld_rsp       (ld_rsp),
        .ld_rsp_ready (ld_rsp_ready)
    );

    read_arbiter u_read_arbiter (
        .clk              (clk),
        .rst_n            (rst_n),
        .ld_rd_req_valid  (ld_rd_req_valid),
        .ld_rd_req        (ld_rd_req),
        .ld_rd_req_ready  (ld_rd_req_ready),
        .if_rd_req_valid  (if_rd_req_valid),
        .if_rd_req        (if_rd_req),
        .if_rd_req_ready  (if_rd_req_ready),
        .ld_rd_rsp_valid  (ld_rd_rsp_valid),
        .ld_rd_rsp        (ld_rd_rsp),
        .ld_rd_rsp_ready  (ld_rd_rsp_ready),
        .if_rd_rsp_valid  (if_rd_rsp_valid),
        .if_rd_rsp        (if_rd_rsp),
        .if_rd_rsp_ready  (if_rd_rsp_ready),
        .ram_rd_req_valid (ram_rd_req_valid),
        .ram_rd_req       (ram_rd_req),
        .ram_rd_req_ready (ram_rd_req_ready),
        .ram_rd_rsp_valid (ram_rd_rsp_valid),
        .ram_rd_rsp       (ram_rd_rsp),
        .ram_rd_rsp_ready (ram_rd_rsp_ready)
    );

    data_ram u_data_ram (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_req_valid (ram_rd_req_valid),
        .rd_req       (ram_rd_req),
        .rd_req_ready (ram_rd_req_ready),
        .rd_rsp_valid (ram_rd_rsp_valid),
        .rd_rsp       (ram_rd_rsp),
        .rd_rsp_ready (ram_rd_rsp_ready),
        .wr_valid     (wr_valid),
        .wr           (wr)
    );

endmodule

/* verification/tb_load_subsys.sv */
`include "mem_defs.svh"

module tb_load_subsys import mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LOADS      = 50;
    localparam int TIMEOUT_CYCLES = NUM_LOADS * 40 + 200;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     ld_req_valid;
    ld_req_t  ld_req;
    logic     ld_req_ready;
    logic     ld_rsp_valid;
    ld_rsp_t  ld_rsp;
    logic     ld_rsp_ready;
    logic     if_rd_req_valid;
    rd_req_t  if_rd_req;
    logic     if_rd_req_ready;
    logic     if_rd_rsp_valid;
    rd_rsp_t  if_rd_rsp;
    logic     if_rd_rsp_ready;
    logic     wr_valid;
    wr_req_t  wr;

    logic [63:0] shadow [256];              // what the ram should hold
    logic [63:0] fetch_exp [$];             // expected fetch data in order
    logic [63:0] fetch_want;
    logic [31:0] lfsr_state = 32'h7b00a88e;
    logic [31:0] dw_addr [8];
    int          errors = 0;
    int          fetch_errors = 0;
    int          cycles = 0;

    load_subsys_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .ld_req_valid    (ld_req_valid),
        .ld_req          (ld_req),
        .ld_req_ready    (ld_req_ready),
        .ld_rsp_valid    (ld_rsp_valid),
        .ld_rsp          (ld_rsp),
        .ld_rsp_ready    (ld_rsp_ready),
        .if_rd_req_valid (if_rd_req_valid),
        .if_rd_req       (if_rd_req),
        .if_rd_req_ready (if_rd_req_ready),
        .if_rd_rsp_valid (if_rd_rsp_valid),
        .if_rd_rsp       (if_rd_rsp),
        .if_rd_rsp_ready (if_rd_rsp_ready),
        .wr_valid        (wr_valid),
        .wr              (wr)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("errors: %0d", errors + fetch_errors);
            $display("Done: errors found");
            $finish;
        end
    end

    // fetch side sink sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && if_rd_rsp_valid && if_rd_rsp_ready) begin
            if (fetch_exp.size() == 0) begin
                fetch_errors++;
                $display("fetch response arrived with no fetch outstanding");
            end else begin
                fetch_want = fetch_exp.pop_front();
                assert (if_rd_rsp.data === fetch_want) else begin
                    fetch_errors++;
                    $display("[FAIL] if_rd_rsp.data got %h expected %h",
                             if_rd_rsp.data, fetch_want);
                end
                assert (if_rd_rsp.id === `ID_W'(`FETCH_ID)) else begin
                    fetch_errors++;
                    $display("[FAIL] if_rd_rsp.id got %h expected %h",
                             if_rd_rsp.id, `ID_W'(`FETCH_ID));
                end
            end
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand32();
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hb4bcd35c) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic int op_bytes(input load_op_e op);
        case (op)
            LB, LBU: return 1;
            LH, LHU: return 2;
            LW, LWU: return 4;
            default: return 8;
        endcase
    endfunction

    // lane picked by the low address bits then extended
    function automatic logic [63:0] expect_load(input load_op_e op, input logic [63:0] word,
                                                input logic [2:0] a);
        logic [63:0] sh;
        sh = word >> (8 * a);
        case (op)
            LB:      return 64'($signed(sh[7:0]));
            LBU:     return 64'(sh[7:0]);
            LH:      return 64'($signed(sh[15:0]));
            LHU:     return 64'(sh[15:0]);
            LW:      return 64'($signed(sh[31:0]));
            LWU:     return 64'(sh[31:0]);
            default: return word;
        endcase
    endfunction

    task automatic compare_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic require_true(input logic cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic verify_load_rsp(input ld_rsp_t rsp, input int lat, input logic [63:0] exp,
                                   input logic [4:0] rd);
        compare_hex("ld_rsp.data", rsp.data, exp);
        compare_hex("ld_rsp.rd", 64'(rsp.rd), 64'(rd));
        require_true(!rsp.fault, "fault flag set on an aligned load");
        require_true(lat >= 4, $sformatf("aligned load answered after only %0d cycles", lat));
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [63:0] data);
        wr_valid  = 1'b1;
        wr.addr   = addr;
        wr.data   = data;
        wr.strb   = 8'hff;
        @(posedge clk);
        #1;
        wr_valid  = 1'b0;
        shadow[addr[10:3]] = data;
    endtask

    // one load; hold keeps ld_rsp_ready low that many cycles after valid
    task automatic do_load(input load_op_e op, input logic [31:0] base, input logic [31:0] off,
                           input logic [4:0] rd, input int hold,
                           output ld_rsp_t rsp, output int lat);
        ld_rsp_t first;
        ld_req_valid  = 1'b1;
        ld_req.op     = op;
        ld_req.base   = base;
        ld_req.offset = off;
        ld_req.rd     = rd;
        @(negedge clk);
        while (!ld_req_ready)
            @(negedge clk);
        @(posedge clk);                     // accepted here
        #1;
        ld_req_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ld_rsp_valid);
        first = ld_rsp;
        repeat (hold) begin
            @(negedge clk);
            require_true(ld_rsp_valid && ld_rsp === first,
                         "ld_rsp changed before it was accepted");
        end
        @(posedge clk);
        #1;
        ld_rsp_ready = 1'b1;
        @(posedge clk);
        #1;
        ld_rsp_ready = 1'b0;
        require_true(!ld_rsp_valid, "ld_rsp still valid after it was accepted");
        rsp = first;
    endtask

    task automatic fetch_read(input logic [31:0] addr);
        if_rd_req_valid = 1'b1;
        if_rd_req.addr  = addr;
        if_rd_req.id    = `ID_W'(`FETCH_ID);
        @(negedge clk);
        while (!if_rd_req_ready)
            @(negedge clk);
        fetch_exp.push_back(shadow[addr[10:3]]);
        @(posedge clk);
        #1;
        if_rd_req_valid = 1'b0;
    endtask

    task automatic hold_fetch_rsp(input int hold);
        rd_rsp_t first;
        @(negedge clk);
        while (!if_rd_rsp_valid)
            @(negedge clk);
        first = if_rd_rsp;
        repeat (hold) begin
            @(negedge clk);
            require_true(if_rd_rsp_valid && if_rd_rsp === first,
                         "if_rd_rsp changed before it was accepted");
        end
        @(posedge clk);
        #1;
        if_rd_rsp_ready = 1'b1;
    endtask

    task automatic doubleword_loads();
        ld_rsp_t rsp;
        int      lat;
        for (int i = 0; i < 8; i++) begin
            dw_addr[i] = 32'h40 + 32'(i) * 24;
            write_word(dw_addr[i], {rand32(), rand32()});
        end
        for (int i = 0; i < 8; i++) begin
            do_load(LD, dw_addr[i], 32'h0, 5'(i + 10), 0, rsp, lat);
            verify_load_rsp(rsp, lat, shadow[dw_addr[i][10:3]], 5'(i + 10));
        end
    endtask

    task automatic lane_extension();
        load_op_e    ops [6];
        logic [63:0] w;
        ld_rsp_t     rsp;
        int          lat;
        int          sz;
        ops = '{LB, LBU, LH, LHU, LW, LWU};
        w = {rand32(), rand32()};
        write_word(32'h100, w);
        foreach (ops[k]) begin
            sz = op_bytes(ops[k]);
            for (int a = 0; a < 8; a += sz) begin
                do_load(ops[k], 32'h100, 32'(a), 5'(a + 1), 0, rsp, lat);
                verify_load_rsp(rsp, lat, expect_load(ops[k], w, 3'(a)), 5'(a + 1));
            end
        end
    endtask

    task automatic address_add();
        logic [31:0] base;
        ld_rsp_t     rsp;
        int          lat;
        write_word(32'h208, {rand32(), rand32()});
        do_load(LD, 32'h208, 32'h0, 5'd3, 0, rsp, lat);
        verify_load_rsp(rsp, lat, shadow[8'h41], 5'd3);
        for (int i = 0; i < 3; i++) begin
            base = rand32();
            do_load(LD, base, 32'h208 - base, 5'd3, 0, rsp, lat);   // sum wraps to 0x208
            verify_load_rsp(rsp, lat, shadow[8'h41], 5'd3);
        end
    endtask

    task automatic misaligned_loads();
        load_op_e    ops [3];
        logic [31:0] offs [3];
        ld_rsp_t     rsp;
        int          lat;
        ops  = '{LH, LW, LD};
        offs = '{32'h3, 32'h6, 32'h4};
        foreach (ops[k]) begin
            do_load(ops[k], 32'h100, offs[k], 5'(k + 20), 0, rsp, lat);
            require_true(rsp.fault, "misaligned load came back without the fault flag");
            compare_hex("ld_rsp.data", rsp.data, 64'h0);
            compare_hex("ld_rsp.rd", 64'(rsp.rd), 64'(k + 20));
            require_true(lat == 1, $sformatf("misaligned load answered after %0d cycles", lat));
        end
    endtask

    task automatic shared_port();
        ld_rsp_t rsp;
        int      lat;
        fork
            for (int i = 0; i < 6; i++)
                fetch_read(dw_addr[7 - i]);
            for (int i = 0; i < 6; i++) begin
                do_load(LD, dw_addr[i], 32'h0, 5'(i + 1), 0, rsp, lat);
                verify_load_rsp(rsp, lat, shadow[dw_addr[i][10:3]], 5'(i + 1));
            end
        join
    endtask

    task automatic held_responses();
        ld_rsp_t rsp;
        int      lat;
        if_rd_rsp_ready = 1'b0;
        fork
            fetch_read(dw_addr[2]);
            hold_fetch_rsp(5);
            begin
                do_load(LD, dw_addr[5], 32'h0, 5'd9, 6, rsp, lat);
                verify_load_rsp(rsp, lat, shadow[dw_addr[5][10:3]], 5'd9);
            end
        join
    endtask

    initial begin
        rst_n           = 1'b0;
        ld_req_valid    = 1'b0;
        ld_req          = '0;
        ld_rsp_ready    = 1'b0;
        if_rd_req_valid = 1'b0;
        if_rd_req       = '0;
        if_rd_rsp_ready = 1'b1;
        wr_valid        = 1'b0;
        wr              = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        require_true(ld_req_ready && !ld_rsp_valid && !if_rd_rsp_valid && !if_rd_req_ready,
                     "outputs not idle after reset");
        doubleword_loads();
        lane_extension();
        address_add();
        misaligned_loads();
        shared_port();
        held_responses();
        repeat (6) @(posedge clk);
        require_true(fetch_exp.size() == 0, "fetch responses missing at the end of the run");
        $display("errors: %0d (load side %0d, fetch side %0d)",
                 errors + fetch_errors, errors, fetch_errors);
        if (errors + fetch_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/mem_pkg.sv
logic/load_unit.sv
logic/read_arbiter.sv
logic/data_ram.sv
logic/load_subsys_top.sv
verification/tb_load_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load path testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_load_subsys -f all.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_load_subsys)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
fi
exit 1
